// ==== ten_gig_mac_tx.f ====
verilog/mac_tx_pkg.sv
verilog/sync_fifo.sv
verilog/frame_buffer.sv
verilog/header_inserter.sv
verilog/crc_appender.sv
verilog/xgmii_encoder.sv
verilog/ten_gig_mac_tx.sv
verification/ten_gig_mac_tx_tb.sv

// ==== verification/ten_gig_mac_tx_tb.sv ====
`timescale 1ns/100ps

module ten_gig_mac_tx_tb;

  localparam int          N_FRAMES = 15;
  localparam logic [47:0] SRC_MAC  = 48'h02_1a_2b_3c_4d_5e;
  localparam logic [7:0]  CH_IDLE  = 8'h07;
  localparam logic [7:0]  CH_START = 8'hFB;
  localparam logic [7:0]  CH_TERM  = 8'hFD;

  logic        i_clk;
  logic        i_rst;
  logic [63:0] i_tdata;
  logic [7:0]  i_tkeep;
  logic        i_tlast;
  logic        i_tvalid;
  logic        o_tready;
  logic [47:0] i_dst_mac;
  logic [15:0] i_ether_type;
  logic [63:0] o_txd;
  logic [7:0]  o_txc;

  // Frame table of payload bytes, destination, EtherType and idle cycles before
  int          tbl_len   [N_FRAMES];
  logic [47:0] tbl_dst   [N_FRAMES];
  logic [15:0] tbl_etype [N_FRAMES];
  int          tbl_idle  [N_FRAMES];

  logic [7:0]  exp_q [$];
  int          len_q [$];
  logic [31:0] lfsr_state;
  logic [31:0] run_crc;
  int          cycle_limit;
  int          mismatches;
  int          other_errors;
  int          frames_seen;
  int          frame_bytes;
  int          gap_bytes;
  int          stall_cycles;
  logic        in_frame;
  logic        monitor_on;

  ten_gig_mac_tx #(
    .P_SRC_MAC    (SRC_MAC),
    .P_FIFO_DEPTH (16),
    .P_GAP_WORDS  (4)
  ) UUT (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_tdata      (i_tdata),
    .i_tkeep      (i_tkeep),
    .i_tlast      (i_tlast),
    .i_tvalid     (i_tvalid),
    .o_tready     (o_tready),
    .i_dst_mac    (i_dst_mac),
    .i_ether_type (i_ether_type),
    .o_txd        (o_txd),
    .o_txc        (o_txc)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  task set_entry(input int idx, input int len, input logic [47:0] dst,
                 input logic [15:0] etype, input int idle);
    tbl_len[idx]   = len;
    tbl_dst[idx]   = dst;
    tbl_etype[idx] = etype;
    tbl_idle[idx]  = idle;
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task take_byte(output logic [7:0] b);
    b = 8'h00;
    for (int k = 0; k < 8; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      b = {b[6:0], lfsr_state[0]};
    end
  endtask

  // Bit-serial reflected CRC-32 with each byte LSB first
  function automatic logic [31:0] crc32_update(input logic [31:0] crc, input logic [7:0] b);
    logic [31:0] c;
    logic        fb;
    c = crc;
    for (int k = 0; k < 8; k++) begin
      fb = c[0] ^ b[k];
      c  = {1'b0, c[31:1]};
      if (fb) begin
        c = c ^ 32'hEDB88320;
      end
    end
    return c;
  endfunction

  task add_frame_byte(input logic [7:0] b);
    exp_q.push_back(b);
    run_crc = crc32_update(run_crc, b);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  task wait_handshake();
    @(negedge i_clk);
    while (!o_tready) begin
      stall_cycles++;
      @(negedge i_clk);
    end
    @(posedge i_clk);
    #2;
  endtask

  task send_frame(input int idx);
    logic [7:0]  payload [128];
    logic [7:0]  pb;
    logic [31:0] fcs;
    int          n_beats;
    int          pos;
    run_crc = 32'hFFFFFFFF;
    exp_q.push_back(CH_START);
    for (int k = 0; k < 6; k++) begin
      exp_q.push_back(8'h55);
    end
    exp_q.push_back(8'hD5);
    for (int k = 5; k >= 0; k--) begin
      add_frame_byte(tbl_dst[idx][8*k +: 8]);
    end
    for (int k = 5; k >= 0; k--) begin
      add_frame_byte(SRC_MAC[8*k +: 8]);
    end
    add_frame_byte(tbl_etype[idx][15:8]);
    add_frame_byte(tbl_etype[idx][7:0]);
    for (int k = 0; k < tbl_len[idx]; k++) begin
      take_byte(pb);
      payload[k] = pb;
      add_frame_byte(pb);
    end
    fcs = ~run_crc;
    for (int k = 0; k < 4; k++) begin
      exp_q.push_back(fcs[8*k +: 8]);
    end
    // Start word, 14 header bytes, payload, FCS
    len_q.push_back(tbl_len[idx] + 26);
    n_beats = (tbl_len[idx] + 7) / 8;
    for (int b = 0; b < n_beats; b++) begin
      for (int lane = 7; lane >= 0; lane--) begin
        pos = 8 * b + 7 - lane;
        i_tdata[8*lane +: 8] = (pos < tbl_len[idx]) ? payload[pos] : 8'h00;
        i_tkeep[lane]        = (pos < tbl_len[idx]);
      end
      i_tlast      = (b == n_beats - 1);
      i_tvalid     = 1'b1;
      i_dst_mac    = tbl_dst[idx];
      i_ether_type = tbl_etype[idx];
      wait_handshake();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Monitor
  ////////////////////////////////////////////////////////////
  task compare_byte(input logic [7:0] b);
    logic [7:0] exp_b;
    if (exp_q.size() == 0) begin
      other_errors++;
      $display("Output byte %02h at %0t has no expected byte left", b, $time);
    end else begin
      exp_b = exp_q.pop_front();
      if (b !== exp_b) begin
        mismatches++;
        $display("MISMATCH at %0t: frame %0d byte %0d expected %02h got %02h",
                 $time, frames_seen, frame_bytes, exp_b, b);
      end
    end
    frame_bytes++;
  endtask

  task check_lane(input int lane, input logic [7:0] b, input logic c);
    int exp_len;
    if (!in_frame && c === 1'b1 && b === CH_START) begin
      if (lane != 7) begin
        mismatches++;
        $display("MISMATCH at %0t: start character expected in lane 7 got lane %0d",
                 $time, lane);
      end
      if (frames_seen > 0 && gap_bytes < 12) begin
        other_errors++;
        $display("Only %0d idle bytes before frame %0d at %0t", gap_bytes, frames_seen, $time);
      end
      in_frame    = 1'b1;
      frame_bytes = 0;
      compare_byte(b);
    end else if (!in_frame) begin
      gap_bytes++;
      if (c !== 1'b1 || b !== CH_IDLE) begin
        mismatches++;
        $display("MISMATCH at %0t: idle lane expected 07/1 got %02h/%b", $time, b, c);
      end
    end else if (c === 1'b0) begin
      compare_byte(b);
    end else if (b === CH_TERM) begin
      in_frame  = 1'b0;
      gap_bytes = 1;
      exp_len   = -1;
      if (len_q.size() > 0) begin
        exp_len = len_q.pop_front();
      end
      if (frame_bytes != exp_len) begin
        other_errors++;
        $display("Frame %0d ended after %0d bytes instead of %0d at %0t",
                 frames_seen, frame_bytes, exp_len, $time);
      end
      frames_seen++;
    end else begin
      mismatches++;
      $display("MISMATCH at %0t: frame %0d byte %0d expected data lane got control %02h",
               $time, frames_seen, frame_bytes, b);
    end
  endtask

  always @(negedge i_clk) begin
    if (monitor_on) begin
      for (int i = 7; i >= 0; i--) begin
        check_lane(i, o_txd[8*i +: 8], o_txc[i]);
      end
    end
  end

  task report_counts();
    $display("Errors: %0d mismatches, %0d other, %0d of %0d frames received",
             mismatches, other_errors, frames_seen, N_FRAMES);
  endtask

  initial begin
    int cycles;
    cycles = 0;
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("Run stopped after %0d cycles before all frames came out", cycle_limit);
    report_counts();
    $display("Verification failed");
    $finish;
  end

  initial begin
    i_rst        = 1'b1;
    i_tdata      = '0;
    i_tkeep      = '0;
    i_tlast      = 1'b0;
    i_tvalid     = 1'b0;
    i_dst_mac    = '0;
    i_ether_type = '0;
    monitor_on   = 1'b0;
    in_frame     = 1'b0;
    mismatches   = 0;
    other_errors = 0;
    frames_seen  = 0;
    frame_bytes  = 0;
    gap_bytes    = 0;
    stall_cycles = 0;
    lfsr_state   = 32'hddb9;
    // Short frames cover every tail length before the long back to back run
    set_entry(0,  46,  48'h0a_1b_2c_3d_4e_5f, 16'h0800, 3);
    set_entry(1,  1,   48'hff_ff_ff_ff_ff_ff, 16'h0806, 6);
    set_entry(2,  2,   48'h00_11_22_33_44_55, 16'h86dd, 0);
    set_entry(3,  3,   48'h66_77_88_99_aa_bb, 16'h88b5, 0);
    set_entry(4,  4,   48'h01_00_5e_00_00_fb, 16'h0800, 5);
    set_entry(5,  5,   48'hcc_dd_ee_ff_00_11, 16'h8100, 0);
    set_entry(6,  7,   48'h12_34_56_78_9a_bc, 16'h88cc, 0);
    set_entry(7,  8,   48'h33_33_00_00_00_01, 16'h86dd, 2);
    set_entry(8,  60,  48'h8e_7d_6c_5b_4a_39, 16'h0800, 0);
    set_entry(9,  17,  48'h28_17_06_f5_e4_d3, 16'h88b6, 0);
    set_entry(10, 72,  48'hc2_b1_a0_9f_8e_7d, 16'h0800, 0);
    set_entry(11, 100, 48'h5c_4b_3a_29_18_07, 16'h86dd, 0);
    set_entry(12, 125, 48'hf6_e5_d4_c3_b2_a1, 16'h0806, 0);
    set_entry(13, 97,  48'h90_8f_7e_6d_5c_4b, 16'h88b5, 0);
    set_entry(14, 128, 48'h3a_29_18_07_f6_e5, 16'h0800, 0);
    cycle_limit = 0;
    for (int i = 0; i < N_FRAMES; i++) begin
      cycle_limit += (tbl_len[i] + 7) / 8 + tbl_idle[i] + 40;
    end
    repeat (5) @(posedge i_clk);
    #2;
    i_rst      = 1'b0;
    monitor_on = 1'b1;
    if (o_tready !== 1'b1) begin
      other_errors++;
      $display("o_tready is not high after reset at %0t", $time);
    end
    for (int i = 0; i < N_FRAMES; i++) begin
      if (tbl_idle[i] > 0) begin
        i_tvalid = 1'b0;
        i_tlast  = 1'b0;
        repeat (tbl_idle[i]) begin
          @(posedge i_clk);
          #2;
        end
      end
      send_frame(i);
    end
    i_tvalid = 1'b0;
    i_tlast  = 1'b0;
    while (frames_seen < N_FRAMES) begin
      @(posedge i_clk);
    end
    // Trailing idle must stay clean
    repeat (10) @(posedge i_clk);
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("%0d expected bytes never came out", exp_q.size());
    end
    if (stall_cycles == 0) begin
      other_errors++;
      $display("o_tready never went low while a beat was waiting");
    end
    report_counts();
    if (mismatches == 0 && other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== verilog/ten_gig_mac_tx.sv ====
`timescale 1ns/100ps

module ten_gig_mac_tx import mac_tx_pkg::*; #(
  parameter mac_t P_SRC_MAC    = 48'h02_00_00_00_00_01,
  parameter int   P_FIFO_DEPTH = 256,
  parameter int   P_GAP_WORDS  = 4
) (
  input  logic     i_clk,
  input  logic     i_rst,
  input  data_t    i_tdata,
  input  keep_t    i_tkeep,
  input  logic     i_tlast,
  input  logic     i_tvalid,
  output logic     o_tready,
  input  mac_t     i_dst_mac,
  input  ethtype_t i_ether_type,
  output data_t    o_txd,
  output keep_t    o_txc
);

  logic    frame_ready;
  header_t header;
  beat_t   beat;
  logic    hdr_pop;
  logic    beat_pop;

  logic    hi_valid;
  data_t   hi_data;
  keep_t   hi_keep;
  logic    hi_sof;
  logic    hi_eof;

  logic    crc_valid;
  data_t   crc_data;
  keep_t   crc_keep;
  logic    crc_sof;
  logic    crc_eof;

  frame_buffer #(.P_FIFO_DEPTH(P_FIFO_DEPTH)) u_frame_buffer (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_tdata       (i_tdata),
    .i_tkeep       (i_tkeep),
    .i_tlast       (i_tlast),
    .i_tvalid      (i_tvalid),
    .o_tready      (o_tready),
    .i_dst_mac     (i_dst_mac),
    .i_ether_type  (i_ether_type),
    .i_hdr_pop     (hdr_pop),
    .i_beat_pop    (beat_pop),
    .o_frame_ready (frame_ready),
    .o_header      (header),
    .o_beat        (beat)
  );

  header_inserter #(.P_SRC_MAC(P_SRC_MAC), .P_GAP_WORDS(P_GAP_WORDS)) u_header_inserter (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_frame_ready (frame_ready),
    .i_header      (header),
    .i_beat        (beat),
    .o_hdr_pop     (hdr_pop),
    .o_beat_pop    (beat_pop),
    .o_valid       (hi_valid),
    .o_data        (hi_data),
    .o_keep        (hi_keep),
    .o_sof         (hi_sof),
    .o_eof         (hi_eof)
  );

  crc_appender u_crc_appender (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (hi_valid),
    .i_data  (hi_data),
    .i_keep  (hi_keep),
    .i_sof   (hi_sof),
    .i_eof   (hi_eof),
    .o_valid (crc_valid),
    .o_data  (crc_data),
    .o_keep  (crc_keep),
    .o_sof   (crc_sof),
    .o_eof   (crc_eof)
  );

  xgmii_encoder u_xgmii_encoder (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (crc_valid),
    .i_data  (crc_data),
    .i_keep  (crc_keep),
    .i_sof   (crc_sof),
    .i_eof   (crc_eof),
    .o_txd   (o_txd),
    .o_txc   (o_txc)
  );

endmodule

// ==== verilog/xgmii_encoder.sv ====
`timescale 1ns/100ps

module xgmii_encoder import mac_tx_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_valid,
  input  data_t i_data,
  input  keep_t i_keep,
  input  logic  i_sof,
  input  logic  i_eof,
  output data_t o_txd,
  output keep_t o_txc
);

  logic [KEEP_W:0] keep_ext;
  data_t           txd_nxt;
  keep_t           txc_nxt;
  logic            term_pending;

  ////////////////////////////////////////////////////////////
  // Lane mapping
  ////////////////////////////////////////////////////////////
  always_comb begin
    // Guard bit above lane 7 places the terminate lane
    keep_ext = {1'b1, i_keep};
    txd_nxt  = {KEEP_W{XG_IDLE}};
    txc_nxt  = '1;
    if (term_pending) begin
      txd_nxt[DATA_W-1 -: 8] = XG_TERM;
    end else if (i_valid && i_sof) begin
      txd_nxt = {XG_START, i_data[DATA_W-9:0]};
      txc_nxt = {1'b1, {(KEEP_W-1){1'b0}}};
    end else if (i_valid) begin
      for (int i = 0; i < KEEP_W; i++) begin
        if (keep_ext[i]) begin
          txd_nxt[8*i +: 8] = i_data[8*i +: 8];
          txc_nxt[i]        = 1'b0;
        end else if (keep_ext[i+1]) begin
          txd_nxt[8*i +: 8] = XG_TERM;
        end
      end
    end
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      o_txd        <= {KEEP_W{XG_IDLE}};
      o_txc        <= '1;
      term_pending <= 1'b0;
    end else begin
      o_txd <= txd_nxt;
      o_txc <= txc_nxt;
      // Terminate goes out alone after a full last word
      term_pending <= i_valid && i_eof && (&i_keep);
    end
  end

endmodule

// ==== verilog/crc_appender.sv ====
`timescale 1ns/100ps

module crc_appender import mac_tx_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_valid,
  input  data_t i_data,
  input  keep_t i_keep,
  input  logic  i_sof,
  input  logic  i_eof,
  output logic  o_valid,
  output data_t o_data,
  output keep_t o_keep,
  output logic  o_sof,
  output logic  o_eof
);

  function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
    logic [31:0] c;
    c = crc ^ {24'h0, b};
    for (int k = 0; k < 8; k++) begin
      c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
    end
    return c;
  endfunction

  logic [31:0]  crc_q;
  logic [31:0]  crc_nxt;
  logic [31:0]  fcs;
  data_t        data_m;
  logic [3:0]   n_bytes;
  logic [127:0] ext;
  logic [15:0]  tot_keep;
  logic         spill;
  logic         spill_q;
  data_t        spill_data;
  keep_t        spill_keep;

  ////////////////////////////////////////////////////////////
  // CRC over kept lanes from lane 7 down
  ////////////////////////////////////////////////////////////
  always_comb begin
    crc_nxt = crc_q;
    data_m  = '0;
    n_bytes = '0;
    for (int i = KEEP_W - 1; i >= 0; i--) begin
      if (i_keep[i]) begin
        crc_nxt           = crc_byte(crc_nxt, i_data[8*i +: 8]);
        data_m[8*i +: 8]  = i_data[8*i +: 8];
        n_bytes           = n_bytes + 4'd1;
      end
    end
    fcs = ~crc_nxt;
    // FCS goes out LSB first, so byte 0 sits highest
    ext = {data_m, 64'h0} |
          ({fcs[7:0], fcs[15:8], fcs[23:16], fcs[31:24], 96'h0} >> (8 * n_bytes));
    tot_keep = ~(16'hffff >> (n_bytes + 4'd4));
    spill    = tot_keep[7];
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      crc_q <= i_sof ? CRC_INIT : crc_nxt;
    end
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      o_valid <= 1'b0;
      o_sof   <= 1'b0;
      o_eof   <= 1'b0;
      spill_q <= 1'b0;
    end else begin
      o_valid <= i_valid || spill_q;
      o_sof   <= i_valid && i_sof;
      o_eof   <= (i_valid && i_eof && !spill) || spill_q;
      spill_q <= i_valid && i_eof && spill;
    end
  end

  always_ff @(posedge i_clk) begin
    spill_data <= ext[63:0];
    spill_keep <= tot_keep[7:0];
    if (spill_q) begin
      o_data <= spill_data;
      o_keep <= spill_keep;
    end else if (i_eof) begin
      o_data <= ext[127:64];
      o_keep <= tot_keep[15:8];
    end else begin
      o_data <= i_data;
      o_keep <= i_keep;
    end
  end

  a_keep_contig : assert property (@(posedge i_clk) disable iff (i_rst)
    i_valid |-> (i_keep != '0) && (((~i_keep) & ((~i_keep) + 8'd1)) == 8'd0));

  // Upstream gap leaves room for the held-over word
  a_spill_slot : assert property (@(posedge i_clk) disable iff (i_rst)
    spill_q |-> !i_valid);

endmodule

// ==== verilog/header_inserter.sv ====
`timescale 1ns/100ps

module header_inserter import mac_tx_pkg::*; #(
  parameter mac_t P_SRC_MAC   = 48'h02_00_00_00_00_01,
  parameter int   P_GAP_WORDS = 4
) (
  input  logic    i_clk,
  input  logic    i_rst,
  input  logic    i_frame_ready,
  input  header_t i_header,
  input  beat_t   i_beat,
  output logic    o_hdr_pop,
  output logic    o_beat_pop,
  output logic    o_valid,
  output data_t   o_data,
  output keep_t   o_keep,
  output logic    o_sof,
  output logic    o_eof
);

  localparam int GAP_W = $clog2(P_GAP_WORDS + 2);

  typedef enum logic [2:0] {
    S_GAP,
    S_HDR1,
    S_HDR2,
    S_PAYLOAD,
    S_TAIL
  } state_t;

  state_t           state;
  logic [GAP_W-1:0] gap_cnt;
  logic             gap_done;
  logic             tail_spill;
  header_t          hdr_q;
  logic [47:0]      carry;
  logic [5:0]       carry_keep;

  assign gap_done   = (gap_cnt >= GAP_W'(P_GAP_WORDS));
  assign o_hdr_pop  = (state == S_GAP) && gap_done && i_frame_ready;
  assign o_beat_pop = (state == S_HDR2) || (state == S_PAYLOAD);

  // Last beat bytes 2..7 land in the next word
  assign tail_spill = i_beat.keep[5];

  ////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      state   <= S_GAP;
      gap_cnt <= '0;
      o_valid <= 1'b0;
      o_sof   <= 1'b0;
      o_eof   <= 1'b0;
    end else begin
      o_valid <= 1'b0;
      o_sof   <= 1'b0;
      o_eof   <= 1'b0;
      case (state)
        S_GAP: begin
          if (!gap_done) begin
            gap_cnt <= gap_cnt + 1'b1;
          end
          if (o_hdr_pop) begin
            o_valid <= 1'b1;
            o_sof   <= 1'b1;
            state   <= S_HDR1;
          end
        end
        S_HDR1: begin
          o_valid <= 1'b1;
          state   <= S_HDR2;
        end
        S_HDR2, S_PAYLOAD: begin
          o_valid <= 1'b1;
          if (!i_beat.last) begin
            state <= S_PAYLOAD;
          end else if (tail_spill) begin
            state <= S_TAIL;
          end else begin
            o_eof   <= 1'b1;
            gap_cnt <= '0;
            state   <= S_GAP;
          end
        end
        S_TAIL: begin
          o_valid <= 1'b1;
          o_eof   <= 1'b1;
          gap_cnt <= '0;
          state   <= S_GAP;
        end
        default: state <= S_GAP;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Word assembly
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    case (state)
      S_GAP: begin
        hdr_q  <= i_header;
        o_data <= {XG_START, {6{PREAMBLE_BYTE}}, SFD_BYTE};
        o_keep <= '1;
      end
      S_HDR1: begin
        o_data <= {hdr_q.dst_mac, P_SRC_MAC[47:32]};
        o_keep <= '1;
      end
      S_HDR2: begin
        o_data     <= {P_SRC_MAC[31:0], hdr_q.ether_type, i_beat.data[63:48]};
        o_keep     <= {6'h3f, i_beat.keep[7:6]};
        carry      <= i_beat.data[47:0];
        carry_keep <= i_beat.keep[5:0];
      end
      S_PAYLOAD: begin
        o_data     <= {carry, i_beat.data[63:48]};
        o_keep     <= {6'h3f, i_beat.keep[7:6]};
        carry      <= i_beat.data[47:0];
        carry_keep <= i_beat.keep[5:0];
      end
      default: begin
        o_data <= {carry, 16'h0000};
        o_keep <= {carry_keep, 2'b00};
      end
    endcase
  end

endmodule

// ==== verilog/frame_buffer.sv ====
`timescale 1ns/100ps

module frame_buffer import mac_tx_pkg::*; #(
  parameter int P_FIFO_DEPTH = 256
) (
  input  logic     i_clk,
  input  logic     i_rst,
  input  data_t    i_tdata,
  input  keep_t    i_tkeep,
  input  logic     i_tlast,
  input  logic     i_tvalid,
  output logic     o_tready,
  input  mac_t     i_dst_mac,
  input  ethtype_t i_ether_type,
  input  logic     i_hdr_pop,
  input  logic     i_beat_pop,
  output logic     o_frame_ready,
  output header_t  o_header,
  output beat_t    o_beat
);

  beat_t   in_beat;
  header_t in_hdr;
  logic    push;
  logic    beat_full;
  logic    hdr_full;
  logic    hdr_empty;
  logic    in_frame;

  assign o_tready = !beat_full && !hdr_full;
  assign push     = i_tvalid && o_tready;

  always_comb begin
    in_beat.data      = i_tdata;
    in_beat.keep      = i_tkeep;
    in_beat.last      = i_tlast;
    in_hdr.dst_mac    = i_dst_mac;
    in_hdr.ether_type = i_ether_type;
  end

  sync_fifo #(.T(beat_t), .DEPTH(P_FIFO_DEPTH)) u_beat_fifo (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_push  (push),
    .i_din   (in_beat),
    .i_pop   (i_beat_pop),
    .o_dout  (o_beat),
    .o_full  (beat_full),
    .o_empty ()
  );

  // One entry per frame written with its last beat
  sync_fifo #(.T(header_t), .DEPTH(P_FIFO_DEPTH)) u_hdr_fifo (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_push  (push && i_tlast),
    .i_din   (in_hdr),
    .i_pop   (i_hdr_pop),
    .o_dout  (o_header),
    .o_full  (hdr_full),
    .o_empty (hdr_empty)
  );

  assign o_frame_ready = !hdr_empty;

  // Open between header pop and last beat pop
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      in_frame <= 1'b0;
    end else if (i_hdr_pop) begin
      in_frame <= 1'b1;
    end else if (i_beat_pop && o_beat.last) begin
      in_frame <= 1'b0;
    end
  end

  a_frame_order : assert property (@(posedge i_clk) disable iff (i_rst)
    (i_hdr_pop |-> !in_frame) and (i_beat_pop |-> in_frame));

endmodule

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/100ps

module sync_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 16
) (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_push,
  input  T     i_din,
  input  logic i_pop,
  output T     o_dout,
  output logic o_full,
  output logic o_empty
);

  localparam int AW = $clog2(DEPTH);

  T mem [DEPTH];

  // Extra MSB tells full from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      mem[wr_ptr[AW-1:0]] <= i_din;
    end
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Head entry shows without a read strobe
  assign o_dout  = mem[rd_ptr[AW-1:0]];
  assign o_empty = (wr_ptr == rd_ptr);
  assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  a_no_overflow : assert property (
    @(posedge i_clk) disable iff (i_rst) i_push |-> !o_full);

  a_no_underflow : assert property (
    @(posedge i_clk) disable iff (i_rst) i_pop |-> !o_empty);

endmodule

// ==== verilog/mac_tx_pkg.sv ====
package mac_tx_pkg;

  ////////////////////////////////////////////////////////////
  // Word and field widths
  ////////////////////////////////////////////////////////////
  localparam int DATA_W = 64;
  localparam int KEEP_W = 8;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [KEEP_W-1:0] keep_t;
  typedef logic [47:0]       mac_t;
  typedef logic [15:0]       ethtype_t;

  // XGMII control characters
  localparam logic [7:0] XG_IDLE  = 8'h07;
  localparam logic [7:0] XG_START = 8'hFB;
  localparam logic [7:0] XG_TERM  = 8'hFD;

  localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
  localparam logic [7:0] SFD_BYTE      = 8'hD5;

  // Payload FIFO entry
  typedef struct packed {
    data_t data;
    keep_t keep;
    logic  last;
  } beat_t;

  // Header FIFO entry
  typedef struct packed {
    mac_t     dst_mac;
    ethtype_t ether_type;
  } header_t;

  // Reflected CRC-32
  localparam logic [31:0] CRC_POLY = 32'hEDB88320;
  localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

endpackage
